/* hw/vedic_defs.svh */
////////////////////
// Vedic MAC width definitions
// Operand, product and accumulator sizes shared by
// the multiplier datapath and the accumulate stage
////////////////////

`ifndef VEDIC_DEFS_SVH
`define VEDIC_DEFS_SVH

// Multiplier operand width, split into two halves
`define VEDIC_WIDTH 12

// Full product, twice the operand
`define VEDIC_PROD_WIDTH 24

// Running sum
`define MAC_ACC_WIDTH 32

`endif

/* hw/vedic_types_pkg.sv */
////////////////////
// Vedic multiplier types
// Vector types for operands, quadrant halves and products
////////////////////

`default_nettype none

`include "vedic_defs.svh"

package vedic_types_pkg;

    ////////////////////
    // Full width

    typedef logic [`VEDIC_WIDTH-1:0]      operand_t;  // 12-bit operand
    typedef logic [`VEDIC_PROD_WIDTH-1:0] product_t;  // 24-bit product

    ////////////////////
    // Quadrant width

    // One half of an operand, fed to a 6x6 block
    typedef logic [`VEDIC_WIDTH/2-1:0]    half_operand_t;

    // Product of two halves
    typedef logic [`VEDIC_WIDTH-1:0]      half_product_t;

endpackage

`default_nettype wire

/* hw/mac_ctrl_pkg.sv */
////////////////////
// MAC control types
// Operation code and running sum type for the
// accumulate stage
////////////////////

`default_nettype none

`include "vedic_defs.svh"

package mac_ctrl_pkg;

    ////////////////////
    // Operation select

    typedef enum logic {
        MAC_OP_LOAD = 1'b0,  // Sum takes the product
        MAC_OP_ACC  = 1'b1   // Product added to sum
    } mac_op_t;

    ////////////////////
    // Accumulator

    // Wraps modulo 2^32, carry goes to the overflow flag
    typedef logic [`MAC_ACC_WIDTH-1:0] acc_t;

endpackage

`default_nettype wire

/* hw/cla_adder.sv */
////////////////////
// Carry-lookahead adder
// 4-bit lookahead groups, ripple between groups,
// zero carry-in, carry out on c
////////////////////

`timescale 1ns/1ps
`default_nettype none

module cla_adder #(
    parameter int WIDTH = 12
) (
    input  wire logic [WIDTH-1:0] a,
    input  wire logic [WIDTH-1:0] b,
    output logic      [WIDTH-1:0] sum,
    output logic                  c      // Carry out
);

    localparam int NGRP = (WIDTH + 3) / 4;  // Groups, last one may be partial
    localparam int PW   = NGRP * 4;         // Padded width

    logic [PW-1:0] gen;  // Bit generate
    logic [PW-1:0] prp;  // Bit propagate
    logic [PW:0]   cy;   // Carry into each bit

    // Zero padding gives g = p = 0 above WIDTH
    assign gen   = PW'(a) & PW'(b);
    assign prp   = PW'(a) ^ PW'(b);
    assign cy[0] = 1'b0;

    for (genvar k = 0; k < NGRP; k++) begin : g_grp
        localparam int B = 4 * k;  // Group base bit

        // Lookahead within the group from its carry-in
        assign cy[B+1] = gen[B] | (prp[B] & cy[B]);
        assign cy[B+2] = gen[B+1] | (prp[B+1] & gen[B])
                       | (prp[B+1] & prp[B] & cy[B]);
        assign cy[B+3] = gen[B+2] | (prp[B+2] & gen[B+1])
                       | (prp[B+2] & prp[B+1] & gen[B])
                       | (prp[B+2] & prp[B+1] & prp[B] & cy[B]);
        assign cy[B+4] = gen[B+3] | (prp[B+3] & gen[B+2])          // Group carry out
                       | (prp[B+3] & prp[B+2] & gen[B+1])
                       | (prp[B+3] & prp[B+2] & prp[B+1] & gen[B])
                       | (prp[B+3] & prp[B+2] & prp[B+1] & prp[B] & cy[B]);
    end

    assign sum = prp[WIDTH-1:0] ^ cy[WIDTH-1:0];
    assign c   = cy[WIDTH];  // Taken mid-group when WIDTH is not a multiple of 4

endmodule

`default_nettype wire

/* hw/vedic_mul3x3.sv */
////////////////////
// 3x3 Vedic base multiplier
// Vertical and crosswise column sums, carries resolved
// column by column into a 6-bit product
////////////////////

`timescale 1ns/1ps
`default_nettype none

module vedic_mul3x3 (
    input  wire logic [2:0] a,
    input  wire logic [2:0] b,
    output logic      [5:0] rslt
);

    ////////////////////
    // Column sums

    logic       col0;  // Vertical, low bits
    logic [1:0] col1;  // Crosswise pair
    logic [2:0] col2;  // Three products plus carry
    logic [2:0] col3;  // Crosswise pair plus carry
    logic [1:0] col4;  // Vertical, high bits plus carry

    assign col0 = a[0] & b[0];

    assign col1 = {1'b0, a[1] & b[0]} + {1'b0, a[0] & b[1]};

    // Up to 4 here
    assign col2 = 3'(a[2] & b[0]) + 3'(a[1] & b[1]) + 3'(a[0] & b[2])
                + 3'(col1[1]);

    // Carry in from col2 can be 2
    assign col3 = 3'(a[2] & b[1]) + 3'(a[1] & b[2]) + 3'(col2[2:1]);

    // Never above 3 since 7*7 fits 6 bits
    assign col4 = 2'(a[2] & b[2]) + col3[2:1];

    ////////////////////
    // Product

    assign rslt = {col4, col3[0], col2[0], col1[0], col0};

endmodule

`default_nettype wire

/* hw/vedic_mul6x6.sv */
////////////////////
// 6x6 Vedic multiplier
// Four 3x3 quadrant products merged by three
// 6-bit lookahead adders
////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "vedic_defs.svh"

module vedic_mul6x6 import vedic_types_pkg::*; (
    input  wire half_operand_t a,
    input  wire half_operand_t b,
    output half_product_t      rslt
);

    localparam int QW = `VEDIC_WIDTH / 2;  // Quadrant product width

    logic [QW-1:0] q_ll;  // aL * bL
    logic [QW-1:0] q_lh;  // aL * bH
    logic [QW-1:0] q_hl;  // aH * bL
    logic [QW-1:0] q_hh;  // aH * bH

    vedic_mul3x3 u_mul_ll (.a(a[2:0]), .b(b[2:0]), .rslt(q_ll));
    vedic_mul3x3 u_mul_lh (.a(a[2:0]), .b(b[5:3]), .rslt(q_lh));
    vedic_mul3x3 u_mul_hl (.a(a[5:3]), .b(b[2:0]), .rslt(q_hl));
    vedic_mul3x3 u_mul_hh (.a(a[5:3]), .b(b[5:3]), .rslt(q_hh));

    ////////////////////
    // Middle term

    logic [QW-1:0] mid_sum;   // Cross products
    logic          mid_c;
    logic [QW-1:0] mid2_sum;  // Plus high half of q_ll
    logic          mid2_c;
    logic          hi_cin;    // Only one of the two carries can fire

    cla_adder #(.WIDTH(QW)) u_add_cross (
        .a   (q_lh),
        .b   (q_hl),
        .sum (mid_sum),
        .c   (mid_c)
    );

    cla_adder #(.WIDTH(QW)) u_add_mid (
        .a   ({3'b0, q_ll[5:3]}),
        .b   (mid_sum),
        .sum (mid2_sum),
        .c   (mid2_c)
    );

    assign hi_cin = mid_c | mid2_c;

    ////////////////////
    // High term

    logic [QW-1:0] hi_sum;

    // Carry out always zero, product fits 12 bits
    cla_adder #(.WIDTH(QW)) u_add_hi (
        .a   (q_hh),
        .b   ({2'b0, hi_cin, mid2_sum[5:3]}),
        .sum (hi_sum),
        .c   ()
    );

    assign rslt = {hi_sum, mid2_sum[2:0], q_ll[2:0]};

endmodule

`default_nettype wire

/* hw/vedic_mul12x12.sv */
////////////////////
// 12x12 Vedic multiplier
// Four 6x6 quadrant products merged by three
// 12-bit lookahead adders into a 24-bit product
////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "vedic_defs.svh"

module vedic_mul12x12 import vedic_types_pkg::*; (
    input  wire operand_t a,
    input  wire operand_t b,
    output product_t      rslt
);

    ////////////////////
    // Quadrant products

    half_product_t q_ll;  // aL * bL, weight 1
    half_product_t q_lh;  // aL * bH, weight 2^6
    half_product_t q_hl;  // aH * bL, weight 2^6
    half_product_t q_hh;  // aH * bH, weight 2^12

    vedic_mul6x6 u_mul_ll (.a(a[5:0]),  .b(b[5:0]),  .rslt(q_ll));
    vedic_mul6x6 u_mul_lh (.a(a[5:0]),  .b(b[11:6]), .rslt(q_lh));
    vedic_mul6x6 u_mul_hl (.a(a[11:6]), .b(b[5:0]),  .rslt(q_hl));
    vedic_mul6x6 u_mul_hh (.a(a[11:6]), .b(b[11:6]), .rslt(q_hh));

    ////////////////////
    // Cross sum

    half_product_t cross_sum;
    logic          cross_c;

    cla_adder #(.WIDTH(`VEDIC_WIDTH)) u_add_cross (
        .a   (q_lh),
        .b   (q_hl),
        .sum (cross_sum),
        .c   (cross_c)
    );

    // Fold in upper half of the low product
    half_product_t mid_sum;
    logic          mid_c;

    cla_adder #(.WIDTH(`VEDIC_WIDTH)) u_add_mid (
        .a   ({6'b0, q_ll[11:6]}),
        .b   (cross_sum),
        .sum (mid_sum),
        .c   (mid_c)
    );

    // Sum stays below 2^13, at most one carry set
    logic hi_cin;

    assign hi_cin = cross_c | mid_c;

    ////////////////////
    // High product

    half_product_t hi_sum;

    cla_adder #(.WIDTH(`VEDIC_WIDTH)) u_add_hi (
        .a   (q_hh),
        .b   ({5'b0, hi_cin, mid_sum[11:6]}),
        .sum (hi_sum),
        .c   ()                                  // 4095*4095 fits, never set
    );

    assign rslt = {hi_sum, mid_sum[5:0], q_ll[5:0]};

endmodule

`default_nettype wire

/* hw/vedic_mul_pipe.sv */
////////////////////
// Multiplier pipeline
// Operand register, 12x12 Vedic multiplier, product
// register. Two operations in flight
////////////////////

`timescale 1ns/1ps
`default_nettype none

module vedic_mul_pipe import vedic_types_pkg::*, mac_ctrl_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     in_valid,   // One-cycle strobe
    input  wire mac_op_t  op,
    input  wire operand_t a,
    input  wire operand_t b,
    output logic          prod_valid,
    output mac_op_t       prod_op,
    output product_t      product
);

    ////////////////////
    // Stage 1, operands

    logic     stg1_valid;
    mac_op_t  stg1_op;
    operand_t stg1_a;
    operand_t stg1_b;

    always_ff @(posedge clk) begin
        if (rst) begin
            stg1_valid <= 1'b0;
        end else begin
            stg1_valid <= in_valid;
        end
    end

    // Captured on strobe only
    always_ff @(posedge clk) begin
        if (in_valid) begin
            stg1_op <= op;
            stg1_a  <= a;
            stg1_b  <= b;
        end
    end

    product_t mul_rslt;  // Combinational product

    vedic_mul12x12 u_mul (
        .a    (stg1_a),
        .b    (stg1_b),
        .rslt (mul_rslt)
    );

    ////////////////////
    // Stage 2, product

    always_ff @(posedge clk) begin
        if (rst) begin
            prod_valid <= 1'b0;
        end else begin
            prod_valid <= stg1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (stg1_valid) begin
            prod_op <= stg1_op;   // Op follows its product
            product <= mul_rslt;
        end
    end

endmodule

`default_nettype wire

/* hw/vedic_accum.sv */
////////////////////
// Product accumulator
// Loads or adds each valid product into a 32-bit sum,
// sticky overflow on adder carry out
////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "vedic_defs.svh"

module vedic_accum import vedic_types_pkg::*, mac_ctrl_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     prod_valid,
    input  wire mac_op_t  prod_op,
    input  wire product_t product,
    output logic          out_valid,
    output acc_t          result,     // New sum, one cycle after the product
    output logic          overflow
);

    acc_t sum_q;      // Running sum
    acc_t prod_ext;   // Product zero-extended
    acc_t add_sum;
    logic add_carry;  // Wrap past 2^32

    assign prod_ext = acc_t'(product);

    cla_adder #(.WIDTH(`MAC_ACC_WIDTH)) u_add_acc (
        .a   (sum_q),
        .b   (prod_ext),
        .sum (add_sum),
        .c   (add_carry)
    );

    ////////////////////
    // Sum and flag

    always_ff @(posedge clk) begin
        if (rst) begin
            sum_q    <= '0;
            overflow <= 1'b0;
        end else if (prod_valid) begin
            if (prod_op == MAC_OP_LOAD) begin
                sum_q    <= prod_ext;
                overflow <= 1'b0;                    // Fresh sum, flag cleared
            end else begin
                sum_q    <= add_sum;                 // Modulo 2^32
                overflow <= overflow | add_carry;    // Sticky
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= prod_valid;
        end
    end

    // Held between products
    assign result = sum_q;

endmodule

`default_nettype wire

/* hw/vedic_mac.sv */
////////////////////
// Vedic multiply-accumulate, top level
// 12x12 unsigned multiply pipeline feeding a 32-bit
// accumulator. Strobe to result in three clocks
////////////////////

`timescale 1ns/1ps
`default_nettype none

module vedic_mac import vedic_types_pkg::*, mac_ctrl_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     in_valid,   // No back-pressure
    input  wire mac_op_t  op,         // Load or accumulate
    input  wire operand_t a,
    input  wire operand_t b,
    output logic          out_valid,
    output acc_t          result,
    output logic          overflow    // Sticky until next load
);

    ////////////////////
    // Pipe to accumulator

    logic     prod_valid;
    mac_op_t  prod_op;
    product_t product;

    vedic_mul_pipe u_pipe (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .op         (op),
        .a          (a),
        .b          (b),
        .prod_valid (prod_valid),
        .prod_op    (prod_op),
        .product    (product)
    );

    vedic_accum u_accum (
        .clk        (clk),
        .rst        (rst),
        .prod_valid (prod_valid),
        .prod_op    (prod_op),
        .product    (product),
        .out_valid  (out_valid),
        .result     (result),
        .overflow   (overflow)
    );

endmodule

`default_nettype wire

/* verification/tb_vedic_mac_tasks.svh */
////////////////////
// Vedic MAC directed tests
// Each test fills a batch, runs it through the DUT
// and checks every result against the model
////////////////////

`ifndef TB_VEDIC_MAC_TASKS_SVH
`define TB_VEDIC_MAC_TASKS_SVH

task automatic single_load(input operand_t x, input operand_t y);
    batch_op[0] = MAC_OP_LOAD;
    batch_a[0]  = x;
    batch_b[0]  = y;
    run_batch(1);   // Also checks the 3-cycle latency
    expect_idle(2);
endtask

// Corner operands, one op in flight
task automatic test_corners();
    single_load(0, 0);
    single_load(0, 4095);
    single_load(1, 1);
    single_load(1, 4095);
    single_load(4095, 1);
    single_load(63, 63);
    single_load(63, 64);
    single_load(64, 63);
    single_load(64, 4095);
    single_load(4095, 63);
    single_load(4095, 4095);
    check_value(result, 32'd16769025, "4095 * 4095");
endtask

// LOAD on every cycle, pipe kept full
task automatic test_stream();
    int          i;
    logic [31:0] r;
    for (i = 0; i < 32; i++) begin
        batch_op[i] = MAC_OP_LOAD;
        r           = lcg_next();
        batch_a[i]  = r[27:16];
        r           = lcg_next();
        batch_b[i]  = r[27:16];
    end
    run_batch(32);
    expect_idle(3);
endtask

task automatic test_acc_chain();
    int          i;
    logic [31:0] r;
    for (i = 0; i < 20; i++) begin
        batch_op[i] = (i == 0) ? MAC_OP_LOAD : MAC_OP_ACC;  // Chain starts from a load
        r           = lcg_next();
        batch_a[i]  = r[27:16];
        r           = lcg_next();
        batch_b[i]  = r[27:16];
    end
    run_batch(20);
    check_value(overflow, 1'b0, "overflow after short chain");
    expect_idle(3);
endtask

// 256 * 16769025 < 2^32 <= 257 * 16769025
task automatic test_overflow();
    int i;
    for (i = 0; i < 260; i++) begin
        batch_op[i] = (i == 0) ? MAC_OP_LOAD : MAC_OP_ACC;
        batch_a[i]  = 12'd4095;
        batch_b[i]  = 12'd4095;
    end
    batch_op[260] = MAC_OP_LOAD;  // Clears the flag
    batch_a[260]  = 12'd5;
    batch_b[260]  = 12'd7;
    result_count  = 0;
    first_ovf_at  = -1;
    run_batch(261);
    check_value(first_ovf_at, 256, "first overflow index");
    check_value(result, 32'd35, "sum after load");
    check_value(overflow, 1'b0, "overflow after load");
    expect_idle(3);
endtask

task automatic test_mid_reset();
    drive_op(MAC_OP_LOAD, 12'd100, 12'd200);
    drive_op(MAC_OP_ACC, 12'd300, 12'd400);
    rst      = 1'b1;   // Third op strobed under reset
    in_valid = 1'b1;
    op       = MAC_OP_ACC;
    a        = 12'd500;
    b        = 12'd600;
    expect_idle(1);
    in_valid = 1'b0;
    expect_idle(3);
    rst = 1'b0;
    model_reset();
    expect_idle(4);    // Nothing left in the pipe
    batch_op[0] = MAC_OP_ACC;
    batch_a[0]  = 12'd123;
    batch_b[0]  = 12'd456;
    run_batch(1);
    check_value(result, 32'd56088, "ACC after reset");
    expect_idle(2);
endtask

`endif

/* verification/tb_vedic_mac.sv */
////////////////////
// Vedic MAC testbench
// Directed tests against a reference model of the
// multiply-accumulate with results checked in issue order
////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "vedic_defs.svh"

module tb_vedic_mac import vedic_types_pkg::*, mac_ctrl_pkg::*; ();

    localparam int LATENCY = 3;    // Strobe to out_valid in clocks
    localparam int MAX_OPS = 300;

    logic     clk;
    logic     rst;
    logic     in_valid;
    mac_op_t  op;
    operand_t a;
    operand_t b;
    logic     out_valid;
    acc_t     result;
    logic     overflow;

    acc_t        model_sum;     // Reference sum
    logic        model_ovf;
    acc_t        exp_sum_q[$];  // One entry per issued op
    logic        exp_ovf_q[$];
    logic [31:0] lcg_state;
    int          n_checks;
    int          result_count;
    int          first_ovf_at;  // Result index where overflow first seen

    mac_op_t  batch_op[MAX_OPS];
    operand_t batch_a[MAX_OPS];
    operand_t batch_b[MAX_OPS];

    vedic_mac uut (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .op        (op),
        .a         (a),
        .b         (b),
        .out_valid (out_valid),
        .result    (result),
        .overflow  (overflow)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        n_checks++;
        if (actual !== expected) begin
            $display("** Error at %0t ns: %s, got %0d, expected %0d",
                     $time, what, actual, expected);
            $display("Test failed");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1, "aborted");
    endtask

    // Reference step with the product taken straight from a * b
    task automatic model_step(input mac_op_t o, input operand_t x, input operand_t y);
        product_t    prod;
        logic [32:0] wide;
        prod = {12'd0, x} * {12'd0, y};
        if (o == MAC_OP_LOAD) begin
            model_sum = acc_t'(prod);
            model_ovf = 1'b0;
        end else begin
            wide      = {1'b0, model_sum} + 33'(prod);
            model_sum = wide[31:0];                  // Wraps modulo 2^32
            model_ovf = model_ovf | wide[32];
        end
        exp_sum_q.push_back(model_sum);
        exp_ovf_q.push_back(model_ovf);
    endtask

    task automatic model_reset();
        model_sum = '0;
        model_ovf = 1'b0;
        exp_sum_q.delete();
        exp_ovf_q.delete();
    endtask

    // Called on a falling edge and returns on the next one
    task automatic drive_op(input mac_op_t o, input operand_t x, input operand_t y);
        model_step(o, x, y);
        in_valid = 1'b1;
        op       = o;
        a        = x;
        b        = y;
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic wait_result(input int max_cycles, output int cycles);
        int   n;
        logic seen;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < max_cycles) begin
            @(negedge clk);
            n++;
            seen = out_valid;
        end
        cycles = n;
        if (!seen) begin
            report_failure("Timeout: the result never arrived on out_valid");
        end
    endtask

    task automatic check_front();
        acc_t exp_sum;
        logic exp_ovf;
        if (exp_sum_q.size() == 0) begin
            report_failure("out_valid rose with no operation outstanding");
        end else begin
            exp_sum = exp_sum_q.pop_front();
            exp_ovf = exp_ovf_q.pop_front();
            check_value(result, exp_sum, "result");
            check_value(overflow, exp_ovf, "overflow");
            if (overflow && first_ovf_at < 0) first_ovf_at = result_count;
            result_count++;
        end
    endtask

    // Drive a batch back to back while collecting the results
    task automatic run_batch(input int count);
        int i;
        int j;
        int got;
        fork
            begin
                for (i = 0; i < count; i++) drive_op(batch_op[i], batch_a[i], batch_b[i]);
            end
            begin
                for (j = 0; j < count; j++) begin
                    wait_result((j == 0) ? LATENCY + 8 : 1, got);
                    if (j == 0) begin
                        check_value(got, LATENCY, "cycles to result");  // Strobe to first result
                    end
                    check_front();
                end
            end
        join
    endtask

    task automatic expect_idle(input int cycles);
        int i;
        for (i = 0; i < cycles; i++) begin
            @(negedge clk);
            check_value(out_valid, 1'b0, "out_valid while idle");
        end
    endtask

`include "tb_vedic_mac_tasks.svh"

    ////////////////////
    // Test sequence

    initial begin
        rst          = 1'b1;
        in_valid     = 1'b0;
        op           = MAC_OP_LOAD;
        a            = '0;
        b            = '0;
        lcg_state    = 32'hc525fe67;
        n_checks     = 0;
        result_count = 0;
        first_ovf_at = -1;
        model_reset();
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        test_corners();
        test_stream();
        test_acc_chain();
        test_overflow();
        test_mid_reset();
        if (n_checks == 0) begin
            $display("No checks were run");
            $display("Test failed");
            $fatal(1, "empty run");
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* vedic_mac.f */
+incdir+hw
+incdir+verification
hw/vedic_types_pkg.sv
hw/mac_ctrl_pkg.sv
hw/cla_adder.sv
hw/vedic_mul3x3.sv
hw/vedic_mul6x6.sv
hw/vedic_mul12x12.sv
hw/vedic_mul_pipe.sv
hw/vedic_accum.sv
hw/vedic_mac.sv
verification/tb_vedic_mac.sv

/* Bender.yml */
package:
  name: vedic_mac

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/vedic_types_pkg.sv
      - hw/mac_ctrl_pkg.sv
      - hw/cla_adder.sv
      - hw/vedic_mul3x3.sv
      - hw/vedic_mul6x6.sv
      - hw/vedic_mul12x12.sv
      - hw/vedic_mul_pipe.sv
      - hw/vedic_accum.sv
      - hw/vedic_mac.sv
  - target: test
    include_dirs:
      - hw
      - verification
    files:
      - verification/tb_vedic_mac.sv
